//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module tb_sd_spi_host -Mdir obj_dir -f sd_spi_host.f

run: compile
	./obj_dir/Vtb_sd_spi_host | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/sd_bit_timer.sv
module sd_bit_timer import sd_cmd_pkg::*, sd_ctrl_pkg::*; (
	input  logic        sdclk,
	input  logic        reset,
	input  logic        timer_run,
	input  timer_mode_e timer_mode,
	output logic        timer_done
);
	logic [9:0] count;
	logic [9:0] last; // count value on the final clock of the window

	always_comb begin
		case (timer_mode)
			tm_await: last = 10'(await_clocks - 1);
			tm_frame: last = 10'(frame_bits); // 48 bits plus one idle clock
			default:  last = 10'(gap_clocks - 1);
		endcase
	end

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (!timer_run) begin
			count <= '0;
		end else if (!timer_done) begin
			count <= count + 10'd1;
		end
	end

	assign timer_done = (count == last);
endmodule

//--- design/sd_block_reader.sv
module sd_block_reader import sd_ctrl_pkg::*; (
	input  logic                  sdclk,
	input  logic                  reset,
	input  logic                  dout,
	sd_steer_if.blk               steer,
	output logic [block_bits-1:0] rdata,
	output logic                  blk_done
);
	// one extra bit for the token's trailing zero
	logic [block_bits:0] sr;

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			sr <= '1;
		end else if (steer.blk_clear) begin
			sr <= '1;
		end else if (steer.blk_read && sr[0]) begin
			sr <= {dout, sr[block_bits:1]}; // ones before the token fall out the bottom
		end
	end

	// token zero at bit 0 means the whole block is in
	assign blk_done = ~sr[0];
	assign rdata    = sr[block_bits:1];
endmodule

//--- design/sd_cmd_pkg.sv
package sd_cmd_pkg;

	localparam int frame_bits = 48;

	// fixed start-up frames, crc valid where the card checks it
	localparam logic [frame_bits-1:0] cmd0_frame   = 48'h40_00_00_00_00_95;
	localparam logic [frame_bits-1:0] cmd8_frame   = 48'h48_00_00_01_AA_87;
	localparam logic [frame_bits-1:0] cmd55_frame  = 48'h77_00_00_00_00_65;
	localparam logic [frame_bits-1:0] acmd41_frame = 48'h69_40_00_00_00_77;

	localparam logic [7:0] cmd17_index = 8'h51; // read single block
	localparam logic [7:0] crc_dummy   = 8'hFF;

	// R1 values
	localparam logic [7:0] r1_idle  = 8'h01;
	localparam logic [7:0] r1_ready = 8'h00;

	localparam logic [7:0] r7_check = 8'hAA; // CMD8 echo byte

	// raw view for the shifter, field view for building CMD17
	typedef union packed {
		logic [frame_bits-1:0] raw;
		struct packed {
			logic [7:0]  index;
			logic [31:0] arg;
			logic [7:0]  crc;
		} f;
	} cmd_frame_u;

endpackage

//--- design/sd_cmd_shifter.sv
module sd_cmd_shifter import sd_cmd_pkg::*; (
	input  logic       sdclk,
	input  logic       reset,
	sd_steer_if.cmd    steer,
	output logic       din
);
	logic [frame_bits-1:0] sr;

	// card samples on the rising edge, so change din on the falling one
	always_ff @(negedge sdclk) begin
		if (steer.cmd_load) begin
			sr <= steer.frame.raw;
		end else if (steer.cmd_send) begin
			sr <= {sr[frame_bits-2:0], 1'b1}; // msb first, refill ones
		end
	end

	always_ff @(negedge sdclk or posedge reset) begin
		if (reset) begin
			din <= 1'b1;
		end else if (steer.cmd_send) begin
			din <= sr[frame_bits-1];
		end else begin
			din <= 1'b1; // idle high
		end
	end
endmodule

//--- design/sd_ctrl_fsm.sv
module sd_ctrl_fsm import sd_cmd_pkg::*, sd_ctrl_pkg::*; (
	input  logic               sdclk,
	input  logic               reset,
	input  logic [31:0]        addr,
	input  logic               re,
	input  logic               resp_valid,
	input  logic [7:0]         resp,
	input  logic               r7_valid,
	input  logic [r7_bits-1:0] r7,
	input  logic               blk_done,
	input  logic               timer_done,
	output logic               timer_run,
	output timer_mode_e        timer_mode,
	output logic               cs,
	output logic               init_ok,
	output logic               err,
	output logic               rend,
	sd_steer_if.fsm            steer
);
	ctrl_state_e state, state_d;
	ctrl_state_e cur;              // load state of the command in flight
	ctrl_state_e resume, resume_d; // where the gap leads
	cmd_frame_u  rd_frame;

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			state   <= st_await;
			cur     <= st_await;
			resume  <= st_await;
			init_ok <= 1'b0;
		end else begin
			state  <= state_d;
			resume <= resume_d;
			if (steer.cmd_load) begin
				cur <= state;
			end
			if (state == st_idle) begin
				init_ok <= 1'b1;
			end
		end
	end

	always_comb begin
		state_d  = state;
		resume_d = resume;
		case (state)
			st_await: begin
				if (timer_done) begin
					state_d = st_cmd0;
				end
			end
			st_cmd0, st_cmd8, st_cmd55, st_acmd41, st_cmd17: begin
				state_d = st_send;
			end
			st_send: begin
				if (timer_done) begin
					state_d = st_resp;
				end
			end
			st_resp: begin
				if (cur == st_cmd8) begin
					if (r7_valid) begin
						state_d  = st_error;
						if (r7[r7_bits-1 -: 8] == r1_idle && r7[7:0] == r7_check) begin
							state_d  = st_gap;
							resume_d = st_cmd55;
						end
					end
				end else if (resp_valid) begin
					state_d = st_error; // anything not matched below
					case (cur)
						st_cmd0: begin
							if (resp == r1_idle) begin
								state_d  = st_gap;
								resume_d = st_cmd8;
							end
						end
						st_cmd55: begin
							if (resp == r1_idle || resp == r1_ready) begin
								state_d  = st_gap;
								resume_d = st_acmd41;
							end
						end
						st_acmd41: begin
							if (resp == r1_idle) begin
								state_d  = st_gap;
								resume_d = st_cmd55; // card still busy
							end else if (resp == r1_ready) begin
								state_d  = st_gap;
								resume_d = st_idle;
							end
						end
						st_cmd17: begin
							if (resp == r1_ready) begin
								state_d = st_read;
							end
						end
						default: begin
						end
					endcase
				end
			end
			st_gap: begin
				if (timer_done) begin
					state_d = resume;
				end
			end
			st_read: begin
				if (blk_done) begin
					state_d  = st_gap;
					resume_d = st_done;
				end
			end
			st_idle: begin
				if (re) begin
					state_d = st_cmd17;
				end
			end
			st_done: begin
				if (!re) begin
					state_d = st_idle;
				end
			end
			default: begin
				state_d = st_error;
			end
		endcase
	end

	always_comb begin
		rd_frame.f.index = cmd17_index;
		rd_frame.f.arg   = addr;
		rd_frame.f.crc   = crc_dummy;
	end

	always_comb begin
		case (state)
			st_cmd0:   steer.frame.raw = cmd0_frame;
			st_cmd8:   steer.frame.raw = cmd8_frame;
			st_cmd55:  steer.frame.raw = cmd55_frame;
			st_acmd41: steer.frame.raw = acmd41_frame;
			st_cmd17:  steer.frame     = rd_frame;
			default:   steer.frame.raw = '1;
		endcase
	end

	always_comb begin
		case (state)
			st_send: timer_mode = tm_frame;
			st_gap:  timer_mode = tm_gap;
			default: timer_mode = tm_await;
		endcase
	end

	assign timer_run = state inside {st_await, st_send, st_gap};

	assign steer.cmd_load  = state inside {st_cmd0, st_cmd8, st_cmd55, st_acmd41, st_cmd17};
	assign steer.cmd_send  = (state == st_send);
	assign steer.resp_read = (state == st_resp) && (cur != st_cmd8);
	assign steer.r7_read   = (state == st_resp) && (cur == st_cmd8);
	assign steer.blk_clear = (state == st_cmd17);
	assign steer.blk_read  = (state == st_read);

	// low from the command load through the last data bit
	assign cs   = state inside {st_await, st_gap, st_idle, st_done, st_error};
	assign err  = (state == st_error); // error state never exits
	assign rend = (state == st_done);
endmodule

//--- design/sd_ctrl_pkg.sv
package sd_ctrl_pkg;

	localparam int block_bits   = 4096;
	localparam int await_clocks = 512; // power-up wait, cs high
	localparam int gap_clocks   = 16;
	localparam int r7_bits      = 40;

	typedef enum logic [3:0] {
		st_await,
		st_cmd0, // load states, one cycle each
		st_cmd8,
		st_cmd55,
		st_acmd41,
		st_cmd17,
		st_send,
		st_resp,
		st_gap,
		st_read,
		st_idle,
		st_done,
		st_error
	} ctrl_state_e;

	typedef enum logic [1:0] {
		tm_await,
		tm_frame,
		tm_gap
	} timer_mode_e;

endpackage

//--- design/sd_resp_capture.sv
module sd_resp_capture import sd_ctrl_pkg::*; (
	input  logic               sdclk,
	input  logic               reset,
	input  logic               dout,
	sd_steer_if.resp           steer,
	output logic               resp_valid,
	output logic [7:0]         resp,
	output logic               r7_valid,
	output logic [r7_bits-1:0] r7
);
	// R1, stops once the start bit reaches the top
	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			resp <= '1;
		end else if (!steer.resp_read) begin
			resp <= '1;
		end else if (resp[7]) begin
			resp <= {resp[6:0], dout};
		end
	end

	// R7, same scheme over 40 bits
	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			r7 <= '1;
		end else if (!steer.r7_read) begin
			r7 <= '1;
		end else if (r7[r7_bits-1]) begin
			r7 <= {r7[r7_bits-2:0], dout};
		end
	end

	assign resp_valid = ~resp[7];
	assign r7_valid   = ~r7[r7_bits-1];
endmodule

//--- design/sd_spi_host.sv
module sd_spi_host import sd_ctrl_pkg::*; (
	input  logic                  sdclk,
	input  logic                  reset,
	input  logic                  dout,
	input  logic [31:0]           addr,
	input  logic                  re,
	output logic                  din,
	output logic                  cs,
	output logic [block_bits-1:0] rdata,
	output logic                  init_ok,
	output logic                  err,
	output logic                  rend
);
	logic               resp_valid;
	logic [7:0]         resp;
	logic               r7_valid;
	logic [r7_bits-1:0] r7;
	logic               blk_done;
	logic               timer_run;
	timer_mode_e        timer_mode;
	logic               timer_done;

	sd_steer_if steer ();

	sd_ctrl_fsm u_fsm (
		.sdclk(sdclk), .reset(reset), .addr(addr), .re(re),
		.resp_valid(resp_valid), .resp(resp),
		.r7_valid(r7_valid), .r7(r7),
		.blk_done(blk_done), .timer_done(timer_done),
		.timer_run(timer_run), .timer_mode(timer_mode),
		.cs(cs), .init_ok(init_ok), .err(err), .rend(rend),
		.steer(steer.fsm)
	);

	sd_bit_timer u_timer (
		.sdclk(sdclk), .reset(reset),
		.timer_run(timer_run), .timer_mode(timer_mode),
		.timer_done(timer_done)
	);

	sd_cmd_shifter u_cmd (
		.sdclk(sdclk), .reset(reset), .steer(steer.cmd), .din(din)
	);

	sd_resp_capture u_resp (
		.sdclk(sdclk), .reset(reset), .dout(dout), .steer(steer.resp),
		.resp_valid(resp_valid), .resp(resp),
		.r7_valid(r7_valid), .r7(r7)
	);

	sd_block_reader u_blk (
		.sdclk(sdclk), .reset(reset), .dout(dout), .steer(steer.blk),
		.rdata(rdata), .blk_done(blk_done)
	);
endmodule

//--- design/sd_steer_if.sv
interface sd_steer_if import sd_cmd_pkg::*; ();

	logic       cmd_load;  // pulse
	cmd_frame_u frame;
	logic       cmd_send;  // level, one per frame clock
	logic       resp_read;
	logic       r7_read;
	logic       blk_clear; // pulse
	logic       blk_read;

	modport fsm (
		output cmd_load, frame, cmd_send,
		output resp_read, r7_read,
		output blk_clear, blk_read
	);

	modport cmd (input cmd_load, frame, cmd_send);

	modport resp (input resp_read, r7_read);

	modport blk (input blk_clear, blk_read);

endinterface

//--- sd_spi_host.f
design/sd_cmd_pkg.sv
design/sd_ctrl_pkg.sv
design/sd_steer_if.sv
design/sd_ctrl_fsm.sv
design/sd_bit_timer.sv
design/sd_cmd_shifter.sv
design/sd_resp_capture.sv
design/sd_block_reader.sv
design/sd_spi_host.sv
testbench/sd_card_model.sv
testbench/tb_sd_spi_host.sv

//--- testbench/sd_card_model.sv
module sd_card_model import sd_cmd_pkg::*, sd_ctrl_pkg::*; (
	input  logic sdclk,
	input  logic cs,
	input  logic din,
	output logic dout
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [frame_bits-1:0] frames[$];
	logic [39:0]           replies[$]; // right aligned
	int                    reply_len[$];
	logic [block_bits-1:0] block;

	function automatic void clear();
		frames.delete();
		replies.delete();
		reply_len.delete();
	endfunction

	function automatic void add_r1(input logic [7:0] value);
		replies.push_back({32'h0, value});
		reply_len.push_back(8);
	endfunction

	function automatic void add_r7(input logic [39:0] value);
		replies.push_back(value);
		reply_len.push_back(40);
	endfunction

	function automatic void set_block(input logic [block_bits-1:0] data);
		block = data;
	endfunction

	function automatic int frame_count();
		return frames.size();
	endfunction

	function automatic logic [frame_bits-1:0] frame_at(input int i);
		return frames[i];
	endfunction

	// frame begins with its zero start bit
	task automatic take_frame(output logic [frame_bits-1:0] f);
		int n;
		n = 0;
		f = '1;
		while (n < frame_bits) begin
			@(posedge sdclk);
			if (!cs && (n > 0 || !din)) begin
				f = {f[frame_bits-2:0], din};
				n++;
			end
		end
	endtask

	task automatic send_bits(input logic [39:0] bits, input int len);
		int i;
		for (i = len - 1; i >= 0; i--) begin
			@(negedge sdclk);
			dout = bits[i]; // msb first
		end
	endtask

	task automatic send_block();
		int i;
		repeat ($urandom_range(20, 1)) @(negedge sdclk);
		send_bits(40'hFE, 8); // start token
		for (i = 0; i < block_bits; i++) begin
			@(negedge sdclk);
			dout = block[i];
		end
		@(negedge sdclk);
		dout = 1'b1;
	endtask

	initial begin : serve
		logic [frame_bits-1:0] f;
		logic [39:0]           r;
		int                    len;
		dout = 1'b1;
		forever begin
			take_frame(f);
			frames.push_back(f);
			if (replies.size() > 0) begin
				r = replies.pop_front();
				len = reply_len.pop_front();
				repeat ($urandom_range(8, 1)) @(negedge sdclk);
				send_bits(r, len);
				@(negedge sdclk);
				dout = 1'b1;
				if (f[frame_bits-1 -: 8] == cmd17_index && len == 8 && r[7:0] == r1_ready) begin
					send_block();
				end
			end
		end
	end
endmodule

//--- testbench/tb_sd_spi_host.sv
module tb_sd_spi_host import sd_cmd_pkg::*, sd_ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int init_limit = 5000; // clocks
	localparam int read_limit = 10000;

	logic                  sdclk;
	logic                  reset;
	logic                  dout;
	logic [31:0]           addr;
	logic                  re;
	logic                  din;
	logic                  cs;
	logic [block_bits-1:0] rdata;
	logic                  init_ok;
	logic                  err;
	logic                  rend;

	string test_name;
	int    test_errors;
	int    tests_run;
	int    failed_tests;
	int    total_errors;

	sd_spi_host dut0 (
		.sdclk(sdclk), .reset(reset), .dout(dout), .addr(addr), .re(re),
		.din(din), .cs(cs), .rdata(rdata),
		.init_ok(init_ok), .err(err), .rend(rend)
	);

	sd_card_model card (.sdclk(sdclk), .cs(cs), .din(din), .dout(dout));

	initial begin
		sdclk = 1'b0;
		forever #2 sdclk = ~sdclk;
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %s: passed", test_name);
		end else begin
			$display("test %s: failed with %0d errors", test_name, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
		tests_run++;
	endtask

	task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%s: %s", test_name, what);
			test_errors++;
		end
	endtask

	task automatic apply_reset();
		@(negedge sdclk);
		reset = 1'b1;
		re = 1'b0;
		repeat (3) @(negedge sdclk);
		reset = 1'b0;
	endtask

	task automatic wait_level(input string sig, input logic level, input int limit,
	                          output bit seen);
		int   n;
		logic v;
		seen = 1'b0;
		for (n = 0; n < limit && !seen; n++) begin
			@(negedge sdclk);
			case (sig)
				"init_ok": v = init_ok;
				"err":     v = err;
				default:   v = rend;
			endcase
			seen = (v === level);
		end
	endtask

	function automatic logic [block_bits-1:0] random_block();
		logic [block_bits-1:0] blk;
		int w;
		for (w = 0; w < block_bits / 32; w++) begin
			blk[w*32 +: 32] = $urandom;
		end
		return blk;
	endfunction

	// card replies for the whole start-up, busy = ACMD41 retries
	task automatic bring_up(input int busy, output bit seen);
		int i;
		card.clear();
		card.add_r1(r1_idle);
		card.add_r7({r1_idle, 24'h000001, r7_check});
		for (i = 0; i < busy; i++) begin
			card.add_r1(r1_idle);
			card.add_r1(r1_idle);
		end
		card.add_r1(r1_idle);
		card.add_r1(r1_ready);
		apply_reset();
		wait_level("init_ok", 1'b1, init_limit, seen);
	endtask

	task automatic run_read(input logic [31:0] a, input logic [block_bits-1:0] blk);
		int n;
		int cs_run;
		int w;
		int bad;
		bit seen;
		card.clear();
		card.set_block(blk);
		card.add_r1(r1_ready);
		@(negedge sdclk);
		addr = a;
		re = 1'b1;
		seen = 1'b0;
		cs_run = 0;
		for (n = 0; n < read_limit && !seen; n++) begin
			@(negedge sdclk);
			if (rend) begin
				seen = 1'b1;
			end else if (cs) begin
				cs_run++;
			end else begin
				cs_run = 0;
			end
		end
		check_true(seen, "rend did not rise after the read");
		check_value("cs high clocks before rend", 64'(gap_clocks), 64'(cs_run));
		check_value("frame count", 64'(1), 64'(card.frame_count()));
		if (card.frame_count() > 0) begin
			check_value("cmd17 frame", 64'({cmd17_index, a, crc_dummy}), 64'(card.frame_at(0)));
		end
		bad = -1;
		for (w = 0; w < block_bits / 32; w++) begin
			if (bad < 0 && rdata[w*32 +: 32] !== blk[w*32 +: 32]) begin
				bad = w;
			end
		end
		w = (bad < 0) ? 0 : bad; // first bad word, or word 0
		check_value($sformatf("rdata word %0d", w), 64'(blk[w*32 +: 32]), 64'(rdata[w*32 +: 32]));
	endtask

	task automatic start_up_sequence();
		int busy;
		int i;
		bit seen;
		begin_test("start_up");
		busy = $urandom_range(3);
		bring_up(busy, seen);
		check_true(seen, "init_ok did not rise in time");
		check_value("err", 64'(1'b0), 64'(err));
		check_value("frame count", 64'(2 + 2 * (busy + 1)), 64'(card.frame_count()));
		if (card.frame_count() == 2 + 2 * (busy + 1)) begin
			check_value("cmd0 frame", 64'(cmd0_frame), 64'(card.frame_at(0)));
			check_value("cmd8 frame", 64'(cmd8_frame), 64'(card.frame_at(1)));
			for (i = 0; i <= busy; i++) begin
				check_value("cmd55 frame", 64'(cmd55_frame), 64'(card.frame_at(2 + 2 * i)));
				check_value("acmd41 frame", 64'(acmd41_frame), 64'(card.frame_at(3 + 2 * i)));
			end
		end
		end_test();
	endtask

	task automatic start_up_failure();
		bit seen;
		begin_test("start_up_failure");
		card.clear();
		card.add_r1(8'h05); // illegal command plus idle
		apply_reset();
		wait_level("err", 1'b1, init_limit, seen);
		check_true(seen, "err did not rise after a bad CMD0 response");
		check_value("init_ok", 64'(1'b0), 64'(init_ok));
		check_value("cs", 64'(1'b1), 64'(cs));
		check_value("frame count", 64'(1), 64'(card.frame_count()));
		end_test();
	endtask

	task automatic block_read();
		bit seen;
		begin_test("block_read");
		bring_up(0, seen);
		check_true(seen, "start-up did not finish before the read");
		if (seen) begin
			run_read($urandom, random_block());
		end
		end_test();
	endtask

	task automatic held_end_and_reread();
		int          i;
		bit          held;
		bit          seen;
		logic [31:0] a;
		begin_test("held_end_and_reread");
		held = 1'b1;
		for (i = 0; i < 20; i++) begin
			@(negedge sdclk);
			if (!rend) begin
				held = 1'b0;
			end
		end
		check_true(held, "rend fell while re was still high");
		@(negedge sdclk);
		re = 1'b0;
		wait_level("rend", 1'b0, 8, seen);
		check_true(seen, "rend did not fall after re dropped");
		a = $urandom;
		if (a == addr) begin
			a = ~a;
		end
		run_read(a, random_block());
		@(negedge sdclk);
		re = 1'b0;
		end_test();
	endtask

	task automatic rejected_read();
		int i;
		bit seen;
		bit stayed;
		bit rend_seen;
		begin_test("rejected_read");
		bring_up(0, seen);
		check_true(seen, "start-up did not finish before the read");
		card.add_r1(8'h04); // illegal command
		@(negedge sdclk);
		addr = $urandom;
		re = 1'b1;
		wait_level("err", 1'b1, init_limit, seen);
		check_true(seen, "err did not rise after a rejected CMD17");
		stayed = 1'b1;
		rend_seen = 1'b0;
		for (i = 0; i < 32; i++) begin
			@(negedge sdclk);
			if (!err) begin
				stayed = 1'b0;
			end
			if (rend) begin
				rend_seen = 1'b1;
			end
		end
		check_true(stayed, "err did not stay high");
		check_true(!rend_seen, "rend rose on a rejected read");
		@(negedge sdclk);
		re = 1'b0;
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		re = 1'b0;
		addr = '0;
		tests_run = 0;
		failed_tests = 0;
		total_errors = 0;
		void'($urandom(32'h4761555b));
		start_up_sequence();
		start_up_failure();
		block_read();
		held_end_and_reread();
		rejected_read();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, total_errors);
		if (total_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end
endmodule
